//--- Makefile
# Verilator build and run for the soc testbench

VERILATOR ?= verilator
TOP       ?= tb_soc
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Simulation PASSED

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BIN) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/soc_checker.sv
`timescale 1ns/100ps

module soc_checker (
    input  logic         clk_in,
    input  logic         rst_n,
    input  logic         step,
    input  logic         debug_valid,
    input  logic [31:0]  debug_value,
    input  logic         armed,
    input  logic         count_steps,
    input  logic [31:0]  expected,
    input  int           exp_count,
    input  logic [127:0] test_name,
    input  logic         timed_out,
    output logic         seen,
    output int           tests,
    output int           errors
);

    int   cycles;           // clock edges since reset release
    int   steps;            // step rising edges since reset release
    int   observed;
    logic step_q;
    logic seen_q    = 1'b0;
    int   test_cnt  = 0;
    int   error_cnt = 0;

    assign seen   = seen_q;
    assign tests  = test_cnt;
    assign errors = error_cnt;

    always @(posedge clk_in) begin
        if (!rst_n) begin
            cycles <= 0;
            steps  <= 0;
            step_q <= 1'b0;
        end else begin
            cycles <= cycles + 1;
            step_q <= step;
            if (step && !step_q)
                steps <= steps + 1;   // same edge rule as the core
        end
    end

    ////////////////////////////////////////////////////////////
    // result compare
    ////////////////////////////////////////////////////////////

    always @(posedge clk_in) begin
        if (!armed)
            seen_q <= 1'b0;
        if (rst_n && debug_valid) begin
            observed = count_steps ? steps : cycles;
            if (seen_q) begin
                $display("%s: debug_valid appeared again, value 0x%08h",
                         test_name, debug_value);
                error_cnt <= error_cnt + 1;
            end else if (debug_value !== expected) begin
                $display("[ERROR] %s: debug_value got 0x%08h expected 0x%08h",
                         test_name, debug_value, expected);
                error_cnt <= error_cnt + 1;
            end else if (exp_count >= 0 && observed != exp_count) begin
                $display("%s: debug_valid came after %0d %s instead of %0d", test_name,
                         observed, count_steps ? "step edges" : "cycles", exp_count);
                error_cnt <= error_cnt + 1;
            end else begin
                $display("%s: ok, debug_value 0x%08h", test_name, debug_value);
            end
            if (armed && !seen_q) begin
                test_cnt <= test_cnt + 1;
                seen_q   <= 1'b1;
            end
        end else if (armed && timed_out) begin
            $display("%s: no debug_valid before the timeout", test_name);
            error_cnt <= error_cnt + 1;
            test_cnt  <= test_cnt + 1;
        end
    end

endmodule

//--- bench/soc_props.sv
`timescale 1ns/100ps

module soc_props (
    input logic        clk_in,
    input logic        rst_n,
    input logic        halt,
    input logic        step,
    input logic        debug_valid,
    input logic [31:0] pc
);

    // strobe is a single-cycle pulse
    debug_valid_pulse: assert property (@(posedge clk_in) disable iff (!rst_n)
        debug_valid |=> !debug_valid)
        else $error("debug_valid high for two cycles in a row");

    debug_valid_reset: assert property (@(posedge clk_in) !rst_n |=> !debug_valid)
        else $error("debug_valid high while in reset");

    // halted and no step edge, nothing executes
    pc_hold: assert property (@(posedge clk_in) disable iff (!rst_n)
        (halt && !step) |=> $stable(pc))
        else $error("pc moved while halted without a step edge");

endmodule

bind soc_top soc_props props_i (
    .clk_in(clk_in),
    .rst_n(rst_n),
    .halt(halt),
    .step(step),
    .debug_valid(debug_valid),
    .pc(pc)
);

//--- bench/soc_tb.sv
`timescale 1ns/100ps

module tb_soc;

    localparam int ram_words    = 256;
    localparam int addr_w       = $clog2(ram_words);
    localparam int reset_cycles = 10;
    localparam int idle_cycles  = 12;    // halted cycles before the first step
    localparam int wait_limit   = 200;
    localparam int table_size   = 13;
    localparam logic [11:0] mark_taken = 12'h3c3;
    localparam logic [11:0] mark_fall  = 12'h5a5;

    typedef enum logic [3:0] {
        t_add, t_sub, t_and, t_or, t_xor, t_slt,
        t_mem, t_beq, t_bne, t_step, t_restart
    } kind_e;

    typedef struct packed {
        kind_e       kind;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] expected;
        logic [7:0]  steps;      // step edges to drive, 0 runs free
    } test_t;

    logic              clk_in    = 1'b0;
    logic              rst_n     = 1'b0;
    logic              halt      = 1'b0;
    logic              step      = 1'b0;
    logic              load_en   = 1'b0;
    logic [addr_w-1:0] load_addr = '0;
    logic [31:0]       load_data = '0;
    logic [31:0]       debug_value;
    logic              debug_valid;

    // checker control
    logic         armed       = 1'b0;
    logic         count_steps = 1'b0;
    logic         timed_out   = 1'b0;
    logic [31:0]  expected    = '0;
    int           exp_count   = -1;
    logic [127:0] test_name   = '0;
    logic         seen;
    int           tests_done;
    int           errors;

    test_t       tests_tbl [table_size];
    logic [31:0] prog [$];
    int          runs_total = 0;

    always #2 clk_in = ~clk_in;

    soc_top #(
        .ram_words(ram_words)
    ) soc_top_i (
        .clk_in(clk_in),
        .rst_n(rst_n),
        .halt(halt),
        .step(step),
        .load_en(load_en),
        .load_addr(load_addr),
        .load_data(load_data),
        .debug_value(debug_value),
        .debug_valid(debug_valid)
    );

    soc_checker checker_i (
        .clk_in(clk_in),
        .rst_n(rst_n),
        .step(step),
        .debug_valid(debug_valid),
        .debug_value(debug_value),
        .armed(armed),
        .count_steps(count_steps),
        .expected(expected),
        .exp_count(exp_count),
        .test_name(test_name),
        .timed_out(timed_out),
        .seen(seen),
        .tests(tests_done),
        .errors(errors)
    );

    ////////////////////////////////////////////////////////////
    // rv32i encoders
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] upper);
        return {upper, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] addi_word(input logic [4:0] rd, rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    // funct holds funct7 above funct3
    function automatic logic [31:0] rtype_word(input logic [9:0] funct,
                                               input logic [4:0] rd, rs1, rs2);
        return {funct[9:3], rs2, rs1, funct[2:0], rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] lw_word(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sw_word(input logic [4:0] rs2, rs1,
                                            input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch_word(input logic ne, input logic [4:0] rs1, rs2,
                                                input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, {2'b00, ne}, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [9:0] funct_of(input kind_e kind);
        case (kind)
            t_sub, t_restart: return {7'b0100000, 3'b000};
            t_and:            return {7'd0, 3'b111};
            t_or:             return {7'd0, 3'b110};
            t_xor:            return {7'd0, 3'b100};
            t_slt:            return {7'd0, 3'b010};
            default:          return {7'd0, 3'b000};   // add
        endcase
    endfunction

    // reference results straight from the isa
    function automatic logic [31:0] model_result(input test_t t);
        logic taken;
        taken = (t.kind == t_beq) ? (t.a == t.b) : (t.a != t.b);
        case (t.kind)
            t_add, t_step:    return t.a + t.b;
            t_sub, t_restart: return t.a - t.b;
            t_and:            return t.a & t.b;
            t_or:             return t.a | t.b;
            t_xor:            return t.a ^ t.b;
            t_slt:            return ($signed(t.a) < $signed(t.b)) ? 32'd1 : 32'd0;
            t_mem:            return t.a;
            default:          return taken ? 32'(mark_taken) : 32'(mark_fall);
        endcase
    endfunction

    function automatic logic [127:0] name_of(input kind_e kind, input int run);
        case (kind)
            t_add:   return "add";
            t_sub:   return "sub";
            t_and:   return "and";
            t_or:    return "or";
            t_xor:   return "xor";
            t_slt:   return "slt";
            t_mem:   return "mem round trip";
            t_beq:   return "beq";
            t_bne:   return "bne";
            t_step:  return "halt and step";
            default: return (run == 0) ? "restart first" : "restart second";
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // program generation
    ////////////////////////////////////////////////////////////

    task automatic const_to_reg(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] rounded;
        rounded = value + 32'h800;   // addi sign-extends its low 12 bits
        prog.push_back(lui_word(rd, rounded[31:12]));
        prog.push_back(addi_word(rd, rd, value[11:0]));
    endtask

    task automatic debug_store(input logic [4:0] rs);
        prog.push_back(lui_word(5'd10, 20'h80000));   // x10 = debug address
        prog.push_back(sw_word(rs, 5'd10, 12'd0));
    endtask

    task automatic build_program(input test_t t);
        prog.delete();
        const_to_reg(5'd1, t.a);
        case (t.kind)
            t_mem: begin
                prog.push_back(addi_word(5'd5, 5'd0, t.b[11:0]));
                prog.push_back(sw_word(5'd1, 5'd5, 12'd0));
                prog.push_back(lw_word(5'd6, 5'd5, 12'd0));
                debug_store(5'd6);
            end
            t_beq, t_bne: begin
                const_to_reg(5'd2, t.b);
                prog.push_back(branch_word(t.kind == t_bne, 5'd1, 5'd2, 13'd12));
                prog.push_back(addi_word(5'd3, 5'd0, mark_fall));
                prog.push_back(jal_word(5'd0, 21'd8));            // skip taken arm
                prog.push_back(addi_word(5'd3, 5'd0, mark_taken));
                debug_store(5'd3);
            end
            default: begin
                const_to_reg(5'd2, t.b);
                prog.push_back(rtype_word(funct_of(t.kind), 5'd3, 5'd1, 5'd2));
                debug_store(5'd3);
            end
        endcase
        prog.push_back(jal_word(5'd0, 21'd0));   // park on a self loop
    endtask

    task automatic fill_table();
        kind_e kinds [table_size];
        kinds = '{t_add, t_sub, t_and, t_or, t_xor, t_slt, t_mem,
                  t_beq, t_beq, t_bne, t_bne, t_step, t_restart};
        for (int i = 0; i < table_size; i++) begin
            tests_tbl[i].kind  = kinds[i];
            tests_tbl[i].a     = $urandom();
            tests_tbl[i].b     = $urandom();
            tests_tbl[i].steps = 8'd0;
            case (kinds[i])
                t_mem:        tests_tbl[i].b = 32'($urandom_range(191, 64)) << 2;
                t_beq, t_bne: begin
                    // first of each pair compares equal operands
                    if (i % 2 == 1)
                        tests_tbl[i].b = tests_tbl[i].a;
                    else
                        tests_tbl[i].b = tests_tbl[i].a ^ ($urandom() | 32'h1);
                end
                t_step:       tests_tbl[i].steps = 8'd7;   // instructions up to the store
                default: ;
            endcase
            tests_tbl[i].expected = model_result(tests_tbl[i]);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // test sequencing
    ////////////////////////////////////////////////////////////

    task automatic wait_for_result(input int limit);
        int waited;
        waited = 0;
        while (!seen && waited < limit) begin
            @(posedge clk_in);
            waited++;
        end
        if (!seen) begin
            timed_out <= 1'b1;
            @(posedge clk_in);
            timed_out <= 1'b0;
        end
    endtask

    task automatic run_once(input test_t t, input int run);
        build_program(t);
        @(posedge clk_in);
        rst_n <= 1'b0;
        armed <= 1'b0;
        halt  <= (t.kind == t_step);
        step  <= 1'b0;
        repeat (reset_cycles) @(posedge clk_in);
        foreach (prog[i]) begin   // core held in reset while loading
            load_en   <= 1'b1;
            load_addr <= addr_w'(i);
            load_data <= prog[i];
            @(posedge clk_in);
        end
        load_en     <= 1'b0;
        rst_n       <= 1'b1;
        armed       <= 1'b1;
        expected    <= t.expected;
        test_name   <= name_of(t.kind, run);
        count_steps <= (t.kind == t_step);
        if (t.kind == t_step)
            exp_count <= int'(t.steps);
        else if (t.kind == t_restart)
            exp_count <= prog.size() - 1;   // all but the parking jump
        else
            exp_count <= -1;
        if (t.kind == t_step) begin
            repeat (idle_cycles) @(posedge clk_in);
            for (int i = 0; i < int'(t.steps); i++) begin
                @(posedge clk_in);
                step <= 1'b1;
                repeat (2) @(posedge clk_in);
                step <= 1'b0;
                @(posedge clk_in);
            end
        end
        wait_for_result(wait_limit);
    endtask

    initial begin
        void'($urandom(86));
        fill_table();
        foreach (tests_tbl[i]) begin
            run_once(tests_tbl[i], 0);
            runs_total++;
            if (tests_tbl[i].kind == t_restart) begin
                run_once(tests_tbl[i], 1);   // same program after another reset
                runs_total++;
            end
        end
        repeat (2) @(posedge clk_in);
        $display("%0d of %0d tests finished, %0d errors", tests_done, runs_total, errors);
        if (errors == 0 && tests_done == runs_total)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- common/rv_pkg.sv
package rv_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////

    localparam int xlen = 32;     // data and address width

    ////////////////////////////////////////////////////////////
    // instruction encodings
    ////////////////////////////////////////////////////////////

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_jal    = 7'b1101111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } opcode_e;

    // funct3 values for the supported subset
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_word    = 3'b010;   // lw / sw
    localparam logic [2:0] f3_beq     = 3'b000;
    localparam logic [2:0] f3_bne     = 3'b001;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,      // signed less than
        alu_pass_b    // lui
    } alu_op_e;

    // write-back source
    typedef enum logic [1:0] {
        wb_alu,
        wb_mem,
        wb_pc4
    } wb_sel_e;

    ////////////////////////////////////////////////////////////
    // address map
    ////////////////////////////////////////////////////////////

    localparam logic [xlen-1:0] debug_addr = 32'h8000_0000;   // bit 31 selects debug
    localparam logic [xlen-1:0] nop_instr  = 32'h0000_0013;   // addi x0,x0,0

endpackage

//--- core/alu_execute.sv
`timescale 1ns/100ps

module alu_execute (
    input  logic [rv_pkg::xlen-1:0] pc,
    input  logic [rv_pkg::xlen-1:0] rs1_value,
    input  logic [rv_pkg::xlen-1:0] rs2_value,
    input  logic [rv_pkg::xlen-1:0] imm,
    input  rv_pkg::alu_op_e         alu_op,
    input  logic                    use_imm,
    input  logic                    is_branch,
    input  logic                    branch_ne,
    input  logic                    is_jal,
    output logic [rv_pkg::xlen-1:0] alu_result,
    output logic [rv_pkg::xlen-1:0] next_pc
);

    logic [rv_pkg::xlen-1:0] operand_b;
    logic [rv_pkg::xlen-1:0] pc_plus4;
    logic [rv_pkg::xlen-1:0] target;       // branch and jal share pc+imm
    logic                    operands_eq;
    logic                    taken;

    ////////////////////////////////////////////////////////////
    // alu
    ////////////////////////////////////////////////////////////

    assign operand_b = use_imm ? imm : rs2_value;

    always_comb begin
        case (alu_op)
            rv_pkg::alu_add:    alu_result = rs1_value + operand_b;
            rv_pkg::alu_sub:    alu_result = rs1_value - operand_b;
            rv_pkg::alu_and:    alu_result = rs1_value & operand_b;
            rv_pkg::alu_or:     alu_result = rs1_value | operand_b;
            rv_pkg::alu_xor:    alu_result = rs1_value ^ operand_b;
            rv_pkg::alu_slt: begin
                alu_result = '0;
                alu_result[0] = $signed(rs1_value) < $signed(operand_b);
            end
            rv_pkg::alu_pass_b: alu_result = operand_b;
            default:            alu_result = rs1_value + operand_b;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // branch and next pc
    ////////////////////////////////////////////////////////////

    assign operands_eq = (rs1_value == rs2_value);
    assign taken       = is_branch && (branch_ne ? !operands_eq : operands_eq);

    assign pc_plus4 = pc + 32'd4;
    assign target   = pc + imm;

    assign next_pc = (taken || is_jal) ? target : pc_plus4;

endmodule

//--- core/instr_decoder.sv
`timescale 1ns/100ps

module instr_decoder (
    input  logic [rv_pkg::xlen-1:0] instr,
    output logic [4:0]              rs1,
    output logic [4:0]              rs2,
    output logic [4:0]              rd,
    output logic [rv_pkg::xlen-1:0] imm,
    output rv_pkg::alu_op_e         alu_op,
    output logic                    use_imm,
    output logic                    is_branch,
    output logic                    branch_ne,
    output logic                    is_jal,
    output logic                    mem_write,
    output logic                    reg_write,
    output rv_pkg::wb_sel_e         wb_sel
);

    rv_pkg::opcode_e opcode;
    logic [2:0]      funct3;
    logic            funct7_b5;   // sub vs add

    assign opcode    = rv_pkg::opcode_e'(instr[6:0]);
    assign funct3    = instr[14:12];
    assign funct7_b5 = instr[30];

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    always_comb begin
        // defaults give a no-op
        imm       = {{20{instr[31]}}, instr[31:20]};   // i-type
        alu_op    = rv_pkg::alu_add;
        use_imm   = 1'b0;
        is_branch = 1'b0;
        branch_ne = 1'b0;
        is_jal    = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        wb_sel    = rv_pkg::wb_alu;

        case (opcode)
            rv_pkg::op_lui: begin
                imm       = {instr[31:12], 12'b0};
                alu_op    = rv_pkg::alu_pass_b;
                use_imm   = 1'b1;
                reg_write = 1'b1;
            end
            rv_pkg::op_jal: begin
                imm       = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                             instr[30:21], 1'b0};
                is_jal    = 1'b1;
                reg_write = 1'b1;
                wb_sel    = rv_pkg::wb_pc4;   // link register gets pc+4
            end
            rv_pkg::op_branch: begin
                imm       = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                             instr[11:8], 1'b0};
                is_branch = (funct3 == rv_pkg::f3_beq) || (funct3 == rv_pkg::f3_bne);
                branch_ne = (funct3 == rv_pkg::f3_bne);
            end
            rv_pkg::op_load: begin
                use_imm   = 1'b1;
                reg_write = (funct3 == rv_pkg::f3_word);
                wb_sel    = rv_pkg::wb_mem;
            end
            rv_pkg::op_store: begin
                imm       = {{20{instr[31]}}, instr[31:25], instr[11:7]};   // s-type
                use_imm   = 1'b1;
                mem_write = (funct3 == rv_pkg::f3_word);
            end
            rv_pkg::op_imm: begin
                use_imm   = 1'b1;
                reg_write = (funct3 == rv_pkg::f3_add_sub);   // addi only
            end
            rv_pkg::op_reg: begin
                reg_write = 1'b1;
                case (funct3)
                    rv_pkg::f3_add_sub: alu_op = funct7_b5 ? rv_pkg::alu_sub
                                                           : rv_pkg::alu_add;
                    rv_pkg::f3_slt:     alu_op = rv_pkg::alu_slt;
                    rv_pkg::f3_xor:     alu_op = rv_pkg::alu_xor;
                    rv_pkg::f3_or:      alu_op = rv_pkg::alu_or;
                    rv_pkg::f3_and:     alu_op = rv_pkg::alu_and;
                    default:            reg_write = 1'b0;   // shifts etc not built
                endcase
            end
            default: ;   // unknown opcode stays a no-op
        endcase
    end

endmodule

//--- core/reg_writeback.sv
`timescale 1ns/100ps

module reg_writeback (
    input  logic                    clk_in,
    input  logic                    rst_n,
    input  logic                    enable,
    input  logic [4:0]              rs1,
    input  logic [4:0]              rs2,
    input  logic [4:0]              rd,
    input  logic                    reg_write,
    input  rv_pkg::wb_sel_e         wb_sel,
    input  logic [rv_pkg::xlen-1:0] alu_result,
    input  logic [rv_pkg::xlen-1:0] mem_rdata,
    input  logic [rv_pkg::xlen-1:0] pc,
    output logic [rv_pkg::xlen-1:0] rs1_value,
    output logic [rv_pkg::xlen-1:0] rs2_value
);

    logic [rv_pkg::xlen-1:0] regs [32];
    logic [rv_pkg::xlen-1:0] wb_value;
    logic                    wr_en;

    // write-back source select
    always_comb begin
        case (wb_sel)
            rv_pkg::wb_alu: wb_value = alu_result;
            rv_pkg::wb_mem: wb_value = mem_rdata;
            rv_pkg::wb_pc4: wb_value = pc + 32'd4;   // jal link
            default:        wb_value = alu_result;
        endcase
    end

    assign wr_en = enable && reg_write && (rd != 5'd0);   // x0 stays zero

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[rd] <= wb_value;
        end
    end

    // asynchronous read ports
    assign rs1_value = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_value = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

//--- core/riscv_core.sv
`timescale 1ns/100ps

module riscv_core (
    input  logic                     clk_in,
    input  logic                     rst_n,
    input  logic                     halt,
    input  logic                     step,
    input  logic [rv_pkg::xlen-1:0]  instr,
    input  logic [rv_pkg::xlen-1:0]  dmem_rdata,
    output logic [rv_pkg::xlen-1:0]  pc,
    output logic [rv_pkg::xlen-1:0]  dmem_addr,
    output logic [rv_pkg::xlen-1:0]  dmem_wdata,
    output logic [3:0]               dmem_we
);

    // decode outputs
    logic [4:0]              rs1, rs2, rd;
    logic [rv_pkg::xlen-1:0] imm;
    rv_pkg::alu_op_e         alu_op;
    logic                    use_imm;
    logic                    is_branch;
    logic                    branch_ne;
    logic                    is_jal;
    logic                    mem_write;
    logic                    reg_write;
    rv_pkg::wb_sel_e         wb_sel;

    // datapath
    logic [rv_pkg::xlen-1:0] rs1_value, rs2_value;
    logic [rv_pkg::xlen-1:0] alu_result;
    logic [rv_pkg::xlen-1:0] next_pc;

    logic step_prev;   // step level from last cycle
    logic enable;      // this cycle executes one instruction

    ////////////////////////////////////////////////////////////
    // run control and pc
    ////////////////////////////////////////////////////////////

    assign enable = !halt || (step && !step_prev);

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            pc        <= '0;
            step_prev <= 1'b0;
        end else begin
            step_prev <= step;
            if (enable)
                pc <= next_pc;
        end
    end

    ////////////////////////////////////////////////////////////
    // stages
    ////////////////////////////////////////////////////////////

    instr_decoder decode (
        .instr(instr),
        .rs1(rs1),
        .rs2(rs2),
        .rd(rd),
        .imm(imm),
        .alu_op(alu_op),
        .use_imm(use_imm),
        .is_branch(is_branch),
        .branch_ne(branch_ne),
        .is_jal(is_jal),
        .mem_write(mem_write),
        .reg_write(reg_write),
        .wb_sel(wb_sel)
    );

    alu_execute execute (
        .pc(pc),
        .rs1_value(rs1_value),
        .rs2_value(rs2_value),
        .imm(imm),
        .alu_op(alu_op),
        .use_imm(use_imm),
        .is_branch(is_branch),
        .branch_ne(branch_ne),
        .is_jal(is_jal),
        .alu_result(alu_result),
        .next_pc(next_pc)
    );

    reg_writeback result (
        .clk_in(clk_in),
        .rst_n(rst_n),
        .enable(enable),
        .rs1(rs1),
        .rs2(rs2),
        .rd(rd),
        .reg_write(reg_write),
        .wb_sel(wb_sel),
        .alu_result(alu_result),
        .mem_rdata(dmem_rdata),
        .pc(pc),
        .rs1_value(rs1_value),
        .rs2_value(rs2_value)
    );

    // data bus address always comes from the alu
    assign dmem_addr  = alu_result;
    assign dmem_wdata = rs2_value;
    assign dmem_we    = (enable && mem_write) ? 4'hf : 4'h0;   // whole words only

endmodule

//--- project.f
common/rv_pkg.sv
core/instr_decoder.sv
core/alu_execute.sv
core/reg_writeback.sv
core/riscv_core.sv
verilog/program_ram.sv
verilog/memory_controller.sv
verilog/soc_top.sv
bench/soc_props.sv
bench/soc_checker.sv
bench/soc_tb.sv

//--- verilog/memory_controller.sv
`timescale 1ns/100ps

module memory_controller #(
    parameter int ram_words = 256
) (
    input  logic                         clk_in,
    input  logic                         rst_n,
    input  logic [rv_pkg::xlen-1:0]      dmem_addr,
    input  logic [rv_pkg::xlen-1:0]      dmem_wdata,
    input  logic [3:0]                   dmem_we,
    input  logic [rv_pkg::xlen-1:0]      ram_rdata,
    output logic [rv_pkg::xlen-1:0]      dmem_rdata,
    output logic [$clog2(ram_words)-1:0] ram_addr,
    output logic [rv_pkg::xlen-1:0]      ram_wdata,
    output logic                         ram_we,
    output logic [rv_pkg::xlen-1:0]      debug_value,
    output logic                         debug_valid
);

    localparam int aw = $clog2(ram_words);

    logic                    debug_sel;   // address is in debug space
    logic                    debug_we;
    logic [rv_pkg::xlen-3:0] word_idx;

    ////////////////////////////////////////////////////////////
    // address decode
    ////////////////////////////////////////////////////////////

    assign debug_sel = |(dmem_addr & rv_pkg::debug_addr);   // bit 31

    // byte address to word index, wrapped at the ram size
    assign word_idx = dmem_addr[rv_pkg::xlen-1:2] % (rv_pkg::xlen-2)'(ram_words);
    assign ram_addr = word_idx[aw-1:0];

    assign ram_wdata = dmem_wdata;
    assign ram_we    = (|dmem_we) && !debug_sel;
    assign debug_we  = (|dmem_we) && debug_sel;

    assign dmem_rdata = debug_sel ? debug_value : ram_rdata;

    // debug register and its one-cycle strobe
    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            debug_value <= '0;
            debug_valid <= 1'b0;
        end else begin
            debug_valid <= debug_we;
            if (debug_we)
                debug_value <= dmem_wdata;
        end
    end

endmodule

//--- verilog/program_ram.sv
`timescale 1ns/100ps

module program_ram #(
    parameter int ram_words = 256
) (
    input  logic                         clk_in,
    input  logic [rv_pkg::xlen-1:0]      pc,
    input  logic [$clog2(ram_words)-1:0] ram_addr,
    input  logic [rv_pkg::xlen-1:0]      ram_wdata,
    input  logic                         ram_we,
    input  logic                         load_en,
    input  logic [$clog2(ram_words)-1:0] load_addr,
    input  logic [rv_pkg::xlen-1:0]      load_data,
    output logic [rv_pkg::xlen-1:0]      instr,
    output logic [rv_pkg::xlen-1:0]      ram_rdata
);

    localparam int aw = $clog2(ram_words);

    logic [rv_pkg::xlen-1:0] mem [ram_words];
    logic [rv_pkg::xlen-3:0] fetch_idx;

    // fetch port gives a nop past the end of the array
    assign fetch_idx = pc[rv_pkg::xlen-1:2];
    assign instr = (fetch_idx < (rv_pkg::xlen-2)'(ram_words)) ? mem[fetch_idx[aw-1:0]]
                                                               : rv_pkg::nop_instr;

    assign ram_rdata = mem[ram_addr];   // data read port

    // load port wins over the core
    always_ff @(posedge clk_in) begin
        if (load_en)
            mem[load_addr] <= load_data;
        else if (ram_we)
            mem[ram_addr] <= ram_wdata;
    end

endmodule

//--- verilog/soc_top.sv
`timescale 1ns/100ps

module soc_top #(
    parameter int ram_words = 256
) (
    input  logic                         clk_in,
    input  logic                         rst_n,
    input  logic                         halt,
    input  logic                         step,
    input  logic                         load_en,
    input  logic [$clog2(ram_words)-1:0] load_addr,
    input  logic [rv_pkg::xlen-1:0]      load_data,
    output logic [rv_pkg::xlen-1:0]      debug_value,
    output logic                         debug_valid
);

    // core side
    logic [rv_pkg::xlen-1:0] pc;
    logic [rv_pkg::xlen-1:0] instr;
    logic [rv_pkg::xlen-1:0] dmem_addr;
    logic [rv_pkg::xlen-1:0] dmem_wdata;
    logic [3:0]              dmem_we;
    logic [rv_pkg::xlen-1:0] dmem_rdata;

    // ram data port
    logic [$clog2(ram_words)-1:0] ram_addr;
    logic [rv_pkg::xlen-1:0]      ram_wdata;
    logic                         ram_we;
    logic [rv_pkg::xlen-1:0]      ram_rdata;

    riscv_core core (
        .clk_in(clk_in),
        .rst_n(rst_n),
        .halt(halt),
        .step(step),
        .instr(instr),
        .dmem_rdata(dmem_rdata),
        .pc(pc),
        .dmem_addr(dmem_addr),
        .dmem_wdata(dmem_wdata),
        .dmem_we(dmem_we)
    );

    memory_controller #(
        .ram_words(ram_words)
    ) memory_ctrl (
        .clk_in(clk_in),
        .rst_n(rst_n),
        .dmem_addr(dmem_addr),
        .dmem_wdata(dmem_wdata),
        .dmem_we(dmem_we),
        .ram_rdata(ram_rdata),
        .dmem_rdata(dmem_rdata),
        .ram_addr(ram_addr),
        .ram_wdata(ram_wdata),
        .ram_we(ram_we),
        .debug_value(debug_value),
        .debug_valid(debug_valid)
    );

    program_ram #(
        .ram_words(ram_words)
    ) memory (
        .clk_in(clk_in),
        .pc(pc),
        .ram_addr(ram_addr),
        .ram_wdata(ram_wdata),
        .ram_we(ram_we),
        .load_en(load_en),
        .load_addr(load_addr),
        .load_data(load_data),
        .instr(instr),
        .ram_rdata(ram_rdata)
    );

endmodule
